//--- design/a2cap_consts.svh
// ----------------------------------------------------------------------
// Sizing constants for the bus capture FIFO and the nibble link
// Include wherever FIFO depth or link divide is needed
// ----------------------------------------------------------------------
`ifndef A2CAP_CONSTS_SVH
`define A2CAP_CONSTS_SVH

// Words held by the capture FIFO, keep a power of two
`define A2CAP_FIFO_DEPTH 16

// Occupancy count width, log2(depth) + 1
`define A2CAP_COUNT_W 5

// System cycles per nibble on the ESP32 link
`define A2CAP_QCLK_DIV 4

`endif

//--- design/a2cap_pkg.sv
// ----------------------------------------------------------------------
// Shared types for the Apple II bus capture path
// ----------------------------------------------------------------------
`default_nettype none

package a2cap_pkg;

    // Selection modes of the capture filter
    typedef enum logic [2:0] {
        MODE_ALL      = 3'd0,
        MODE_IO       = 3'd1,   // $C000-$CFFF
        MODE_SYSTEM   = 3'd2,   // Zero page and stack page
        MODE_GRAPHICS = 3'd3,   // Text and hires pages
        MODE_ROM      = 3'd4,   // $D000 and up
        MODE_WRITES   = 3'd5,
        MODE_READS    = 3'd6,
        MODE_SPEAKER  = 3'd7    // $C030 only
    } capture_mode_e;

    typedef struct packed {
        logic       rw_n;
        logic       m2sel_n;
        logic       m2b0;
        logic       sw_gs;      // IIgs mode
        logic [3:0] reserved;
    } bus_flags_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        bus_flags_t  flags;
    } capture_fields_t;

    // Captured word, seen as raw bits by the link side
    typedef union packed {
        logic [31:0]     raw;
        capture_fields_t fields;
    } capture_word_u;

endpackage

`default_nettype wire

//--- design/bus_cycle_if.sv
// ----------------------------------------------------------------------
// One sampled Apple II bus cycle, from the top level to the filter
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface bus_cycle_if;

    logic [15:0] addr;
    logic [7:0]  data;
    logic        rw_n;
    logic        m2sel_n;
    logic        m2b0;
    logic        sw_gs;
    logic        data_in_strobe;    // One pulse per bus cycle

    modport source (
        output addr, data, rw_n, m2sel_n, m2b0, sw_gs, data_in_strobe
    );

    modport sink (
        input addr, data, rw_n, m2sel_n, m2b0, sw_gs, data_in_strobe
    );

endinterface

`default_nettype wire

//--- design/capture_push_if.sv
// ----------------------------------------------------------------------
// Packet push from the capture filter into the stream FIFO
// A word moves on each edge with push_valid high and full low
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface capture_push_if;
    import a2cap_pkg::*;

    logic          push_valid;
    capture_word_u push_word;
    logic          full;
    logic          almost_full;
    logic          empty;

    modport filter (output push_valid, push_word, input full, almost_full, empty);

    modport fifo (input push_valid, push_word, output full, almost_full, empty);

endinterface

`default_nettype wire

//--- design/capture_filter.sv
// ----------------------------------------------------------------------
// Qualifies bus cycles by capture mode and holds the packed word
// until the stream FIFO takes it, also drives the status outputs
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module capture_filter (
    input  logic                     a2bus_if,
    input  logic                     rst,
    bus_cycle_if.sink                bus,
    capture_push_if.filter           push,
    input  logic                     capture_enable,
    input  a2cap_pkg::capture_mode_e capture_mode,
    output logic                     activity_led,
    output logic                     overflow_led,
    output logic [7:0]               debug_status
);
    import a2cap_pkg::*;

    logic          bus_cycle;
    logic          mode_hit;
    logic          trigger;
    logic          trigger_r;
    capture_word_u word_c;

    // ------------------------------------------------------------------
    // Mode selection
    // ------------------------------------------------------------------
    assign bus_cycle = capture_enable & bus.data_in_strobe & ~bus.m2sel_n;

    always_comb begin
        mode_hit = 1'b0;
        case (capture_mode)
            MODE_ALL:      mode_hit = 1'b1;
            MODE_IO:       mode_hit = (bus.addr[15:12] == 4'hC);
            MODE_SYSTEM:   mode_hit = (bus.addr[15:9] == 7'h00);  // Pages 0 and 1
            MODE_GRAPHICS: mode_hit = (bus.addr[15:10] == 6'b000001) |
                                      (bus.addr[15:13] == 3'b001);
            MODE_ROM:      mode_hit = (bus.addr[15:12] >= 4'hD);
            MODE_WRITES:   mode_hit = ~bus.rw_n;
            MODE_READS:    mode_hit = bus.rw_n;
            MODE_SPEAKER:  mode_hit = (bus.addr == 16'hC030);
        endcase
    end

    assign trigger = bus_cycle & mode_hit;

    // Packet layout is address, data, then flags
    always_comb begin
        word_c.fields.addr           = bus.addr;
        word_c.fields.data           = bus.data;
        word_c.fields.flags.rw_n     = bus.rw_n;
        word_c.fields.flags.m2sel_n  = bus.m2sel_n;
        word_c.fields.flags.m2b0     = bus.m2b0;
        word_c.fields.flags.sw_gs    = bus.sw_gs;
        word_c.fields.flags.reserved = 4'b0000;
    end

    // ------------------------------------------------------------------
    // Hold register toward the FIFO
    // ------------------------------------------------------------------
    always_ff @(posedge a2bus_if) begin
        if (rst) begin
            push.push_valid <= 1'b0;
        end else if (trigger) begin
            push.push_valid <= 1'b1;            // New word replaces any held one
        end else if (~push.full) begin
            push.push_valid <= 1'b0;            // Accepted this edge
        end
    end

    always_ff @(posedge a2bus_if) begin
        if (trigger) begin
            push.push_word <= word_c;
        end
    end

    always_ff @(posedge a2bus_if) begin
        if (rst) begin
            trigger_r <= 1'b0;
        end else begin
            trigger_r <= trigger;
        end
    end

    // Status
    assign activity_led = trigger_r | ~push.empty;
    assign overflow_led = push.push_valid & push.full;

    assign debug_status = {
        push.full,
        push.almost_full,
        capture_enable,
        capture_mode,       // Bits 4:2
        push.push_valid,
        trigger_r
    };

endmodule

`default_nettype wire

//--- design/nibble_stream_fifo.sv
// ----------------------------------------------------------------------
// Capture word FIFO and the 4-bit serializer toward the ESP32
// Each word leaves as eight nibbles, MSB first, framed on nibble 0
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "a2cap_consts.svh"

module nibble_stream_fifo (
    input  logic          a2bus_if,
    input  logic          rst,
    capture_push_if.fifo  push,
    output logic          esp_qclk,
    output logic          esp_frame,
    output logic [3:0]    esp_qdata
);

    localparam int PTR_W    = $clog2(`A2CAP_FIFO_DEPTH);
    localparam int DIV_W    = $clog2(`A2CAP_QCLK_DIV);
    localparam int DIV_LAST = `A2CAP_QCLK_DIV - 1;
    localparam int DIV_FALL = `A2CAP_QCLK_DIV / 2 - 1;

    logic [31:0]               mem [`A2CAP_FIFO_DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [`A2CAP_COUNT_W-1:0] count;
    logic                      wr_en;
    logic                      rd_en;

    logic                      busy;
    logic [DIV_W-1:0]          div;
    logic [2:0]                nib_idx;
    logic [31:0]               shift_r;
    logic                      nib_end;
    logic                      word_done;

    // ------------------------------------------------------------------
    // Circular buffer
    // ------------------------------------------------------------------
    assign wr_en = push.push_valid & ~push.full;
    assign rd_en = ~push.empty & (~busy | word_done);

    assign push.full        = (count == `A2CAP_COUNT_W'(`A2CAP_FIFO_DEPTH));
    assign push.almost_full = (count >= `A2CAP_COUNT_W'(`A2CAP_FIFO_DEPTH - 2));
    assign push.empty       = (count == '0);

    always_ff @(posedge a2bus_if) begin
        if (wr_en) begin
            mem[wr_ptr] <= push.push_word.raw;
        end
    end

    always_ff @(posedge a2bus_if) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;     // Depth is a power of two
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Nibble serializer
    // ------------------------------------------------------------------
    assign nib_end   = busy & (div == DIV_W'(DIV_LAST));
    assign word_done = nib_end & (nib_idx == 3'd7);

    always_ff @(posedge a2bus_if) begin
        if (rst) begin
            busy      <= 1'b0;
            div       <= '0;
            nib_idx   <= '0;
            esp_qclk  <= 1'b0;
            esp_frame <= 1'b0;
            esp_qdata <= 4'h0;
        end else if (rd_en) begin
            // Start of a word, may follow the last one directly
            busy      <= 1'b1;
            div       <= '0;
            nib_idx   <= '0;
            esp_qclk  <= 1'b1;
            esp_frame <= 1'b1;
            esp_qdata <= mem[rd_ptr][31:28];
        end else if (word_done) begin
            busy      <= 1'b0;                      // Nothing queued, go idle
            div       <= '0;
            nib_idx   <= '0;
            esp_qclk  <= 1'b0;
            esp_frame <= 1'b0;
            esp_qdata <= 4'h0;
        end else if (nib_end) begin
            div       <= '0;
            nib_idx   <= nib_idx + 1'b1;
            esp_qclk  <= 1'b1;
            esp_frame <= 1'b0;
            esp_qdata <= shift_r[27:24];
        end else if (busy) begin
            div <= div + 1'b1;
            if (div == DIV_W'(DIV_FALL)) esp_qclk <= 1'b0;  // Second half low
        end
    end

    always_ff @(posedge a2bus_if) begin
        if (rd_en) begin
            shift_r <= mem[rd_ptr];
        end else if (nib_end) begin
            shift_r <= {shift_r[27:0], 4'h0};
        end
    end

endmodule

`default_nettype wire

//--- design/a2bus_stream.sv
// ----------------------------------------------------------------------
// Apple II bus capture top level with the ESP32 nibble link
// Plain bus pins in, filtered cycles streamed out as 32-bit words
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module a2bus_stream (
    input  logic        a2bus_if,
    input  logic        rst,
    input  logic [15:0] addr,
    input  logic [7:0]  data,
    input  logic        rw_n,
    input  logic        m2sel_n,
    input  logic        m2b0,
    input  logic        sw_gs,
    input  logic        data_in_strobe,
    input  logic        capture_enable,
    input  logic [2:0]  capture_mode,
    output logic        esp_qclk,
    output logic        esp_frame,
    output logic [3:0]  esp_qdata,
    output logic        activity_led,
    output logic        overflow_led,
    output logic [7:0]  debug_status
);
    import a2cap_pkg::*;

    bus_cycle_if    bus_if ();
    capture_push_if push_if ();

    // Bus pins into the cycle interface
    assign bus_if.addr           = addr;
    assign bus_if.data           = data;
    assign bus_if.rw_n           = rw_n;
    assign bus_if.m2sel_n        = m2sel_n;
    assign bus_if.m2b0           = m2b0;
    assign bus_if.sw_gs          = sw_gs;
    assign bus_if.data_in_strobe = data_in_strobe;

    capture_filter capture_filter_inst (
        .a2bus_if       (a2bus_if),
        .rst            (rst),
        .bus            (bus_if.sink),
        .push           (push_if.filter),
        .capture_enable (capture_enable),
        .capture_mode   (capture_mode_e'(capture_mode)),
        .activity_led   (activity_led),
        .overflow_led   (overflow_led),
        .debug_status   (debug_status)
    );

    nibble_stream_fifo nibble_stream_fifo_inst (
        .a2bus_if  (a2bus_if),
        .rst       (rst),
        .push      (push_if.fifo),
        .esp_qclk  (esp_qclk),
        .esp_frame (esp_frame),
        .esp_qdata (esp_qdata)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// ----------------------------------------------------------------------
// Testbench clock and power-on reset for the bus capture testbench
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic a2bus_if,
    output logic rst
);

    localparam real HALF_PERIOD = 20.0;     // 40 ns clock

    initial begin
        a2bus_if = 1'b0;
        forever #(HALF_PERIOD) a2bus_if = ~a2bus_if;
    end

    // Reset held over the first four rising edges
    initial begin
        rst <= 1'b1;
        repeat (4) @(posedge a2bus_if);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/a2bus_stream_assert.sv
// ----------------------------------------------------------------------
// Concurrent checks on the nibble link and the filter to FIFO push
// Attached to the capture top level by the bind at the end
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module a2bus_stream_assert (
    input logic        a2bus_if,
    input logic        rst,
    input logic        esp_qclk,
    input logic        esp_frame,
    input logic [3:0]  esp_qdata,
    input logic [7:0]  debug_status,
    input logic [31:0] push_word
);

    logic push_valid;
    logic full;
    logic trigger_r;

    assign push_valid = debug_status[1];
    assign full       = debug_status[7];
    assign trigger_r  = debug_status[0];    // High one edge after a word load

    // Frame only starts together with a new nibble clock
    frame_with_qclk_a : assert property (@(posedge a2bus_if) disable iff (rst)
        $rose(esp_frame) |-> $rose(esp_qclk))
        else $error("esp_frame rose without a rising esp_qclk");

    qdata_stable_a : assert property (@(posedge a2bus_if) disable iff (rst)
        (esp_qclk && $past(esp_qclk)) |-> $stable(esp_qdata))
        else $error("esp_qdata changed during the high phase of esp_qclk");

    // Held word only moves when a new trigger replaces it
    push_hold_a : assert property (@(posedge a2bus_if) disable iff (rst)
        (push_valid && $past(push_valid && full) && !trigger_r) |-> $stable(push_word))
        else $error("push_word changed while held against a full FIFO");

endmodule

bind a2bus_stream a2bus_stream_assert a2bus_stream_assert_inst (
    .a2bus_if     (a2bus_if),
    .rst          (rst),
    .esp_qclk     (esp_qclk),
    .esp_frame    (esp_frame),
    .esp_qdata    (esp_qdata),
    .debug_status (debug_status),
    .push_word    (push_if.push_word)
);

`default_nettype wire

//--- testbench/a2bus_stream_tb.sv
// ----------------------------------------------------------------------
// Testbench for the bus capture top, random bus cycles checked
// against a mode model and a nibble receiver on the ESP32 link
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "a2cap_consts.svh"

module a2bus_stream_tb;
    import a2cap_pkg::*;

    localparam int DEPTH    = `A2CAP_FIFO_DEPTH;
    localparam int STROBES  = 8 * 40 + 20 + 5 + 3 * DEPTH + 4;
    localparam int WATCHDOG = 8 * 40 * 40 + 32 * STROBES + 4000;   // Cycles

    logic        a2bus_if;
    logic        rst_por;
    logic        rst_tb;
    logic        rst;
    logic [15:0] addr;
    logic [7:0]  data;
    logic        rw_n;
    logic        m2sel_n;
    logic        m2b0;
    logic        sw_gs;
    logic        data_in_strobe;
    logic        capture_enable;
    logic [2:0]  capture_mode;
    logic        esp_qclk;
    logic        esp_frame;
    logic [3:0]  esp_qdata;
    logic        activity_led;
    logic        overflow_led;
    logic [7:0]  debug_status;

    logic [31:0]   exp_q[$];        // Model output, oldest first
    capture_mode_e cur_mode;
    logic [31:0]   rx_word;
    int            nib_cnt = 0;
    int            rx_count = 0;
    int            frames_seen = 0;
    int            activity_until = 0;
    int            errors = 0;
    int            test_errors = 0;
    int            tests = 0;
    int            words_checked = 0;
    bit            qclk_d = 1'b0;
    bit            subseq_mode = 1'b0;
    bit            overflow_seen = 1'b0;
    bit            verdict_done = 1'b0;

    assign rst = rst_por | rst_tb;

    tb_clock_gen tb_clock_gen_inst (.a2bus_if(a2bus_if), .rst(rst_por));

    a2bus_stream a2bus_stream_inst (
        .a2bus_if       (a2bus_if),
        .rst            (rst),
        .addr           (addr),
        .data           (data),
        .rw_n           (rw_n),
        .m2sel_n        (m2sel_n),
        .m2b0           (m2b0),
        .sw_gs          (sw_gs),
        .data_in_strobe (data_in_strobe),
        .capture_enable (capture_enable),
        .capture_mode   (capture_mode),
        .esp_qclk       (esp_qclk),
        .esp_frame      (esp_frame),
        .esp_qdata      (esp_qdata),
        .activity_led   (activity_led),
        .overflow_led   (overflow_led),
        .debug_status   (debug_status)
    );

    // ------------------------------------------------------------------
    // Model and helpers
    // ------------------------------------------------------------------
    function automatic bit mode_match(input capture_mode_e m, input logic [15:0] a,
                                      input logic rw);
        case (m)
            MODE_ALL:      return 1'b1;
            MODE_IO:       return (a >= 16'hC000) && (a <= 16'hCFFF);
            MODE_SYSTEM:   return a <= 16'h01FF;
            MODE_GRAPHICS: return ((a >= 16'h0400) && (a <= 16'h07FF)) ||
                                  ((a >= 16'h2000) && (a <= 16'h3FFF));
            MODE_ROM:      return a >= 16'hD000;
            MODE_WRITES:   return !rw;
            MODE_READS:    return rw;
            default:       return a == 16'hC030;
        endcase
    endfunction

    // Biased toward the regions the modes select
    function automatic logic [15:0] pick_addr();
        case ($urandom % 6)
            0:       return 16'($urandom);
            1:       return {4'hC, 12'($urandom)};
            2:       return 16'hC030;
            3:       return {7'h00, 9'($urandom)};
            4:       return {3'b001, 13'($urandom)};
            default: return {6'b000001, 10'($urandom)};
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic set_mode(input logic en, input capture_mode_e m);
        @(posedge a2bus_if);
        capture_enable <= en;
        capture_mode   <= m;
        data_in_strobe <= 1'b0;
        cur_mode = m;
    endtask

    task automatic drive_strobe(input logic en, input logic sel_n);
        capture_word_u w;
        w.fields.addr           = pick_addr();
        w.fields.data           = 8'($urandom);
        w.fields.flags.rw_n     = 1'($urandom);
        w.fields.flags.m2sel_n  = sel_n;
        w.fields.flags.m2b0     = 1'($urandom);
        w.fields.flags.sw_gs    = 1'($urandom);
        w.fields.flags.reserved = 4'h0;
        @(posedge a2bus_if);
        addr           <= w.fields.addr;
        data           <= w.fields.data;
        rw_n           <= w.fields.flags.rw_n;
        m2sel_n        <= sel_n;
        m2b0           <= w.fields.flags.m2b0;
        sw_gs          <= w.fields.flags.sw_gs;
        capture_enable <= en;
        data_in_strobe <= 1'b1;
        if (en && !sel_n && mode_match(cur_mode, w.fields.addr, w.fields.flags.rw_n)) begin
            exp_q.push_back(w.raw);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge a2bus_if);
            data_in_strobe <= 1'b0;
        end
    endtask

    task automatic check_idle(input string where);
        if (esp_qclk || esp_frame || (esp_qdata != 4'h0)) begin
            report_error($sformatf("link not idle %s, qclk %b frame %b qdata %h",
                                   where, esp_qclk, esp_frame, esp_qdata));
        end
    endtask

    // Wait until the FIFO is empty, then past the last word on the link
    task automatic drain();
        idle(1);
        @(negedge a2bus_if);
        while (activity_led) @(negedge a2bus_if);
        repeat (40) @(negedge a2bus_if);
        check_idle("after drain");
        if (!subseq_mode && (exp_q.size() != 0)) begin
            report_error($sformatf("%0d expected words never arrived", exp_q.size()));
        end
        exp_q.delete();
    endtask

    task automatic start_test();
        test_errors = 0;
        rx_count    = 0;
    endtask

    task automatic end_test(input int n, input string name);
        tests++;
        $display("Test %0d %-14s %s, %0d words, %0d errors", n, name,
                 (test_errors == 0) ? "passed" : "failed", rx_count, test_errors);
    endtask

    // ------------------------------------------------------------------
    // Nibble receiver
    // ------------------------------------------------------------------
    task automatic check_word(input logic [31:0] w);
        logic [31:0] e;
        int          skipped;
        rx_count++;
        words_checked++;
        skipped = 0;
        if (!subseq_mode) begin
            if (exp_q.size() == 0) begin
                report_error($sformatf("unexpected word %08h", w));
            end else begin
                e = exp_q.pop_front();
                if (w != e) report_error($sformatf("word %08h, expected %08h", w, e));
            end
        end else begin
            while ((exp_q.size() > 0) && (exp_q[0] != w)) begin
                void'(exp_q.pop_front());       // Dropped in the hold register
                skipped++;
            end
            if (exp_q.size() == 0) begin
                report_error($sformatf("word %08h not in expected order", w));
            end else begin
                void'(exp_q.pop_front());
                if ((rx_count <= DEPTH + 1) && (skipped != 0)) begin
                    report_error($sformatf("word %0d is %08h, %0d earlier words lost",
                                           rx_count, w, skipped));
                end
            end
        end
    endtask

    always @(negedge a2bus_if) begin
        if (rst) begin
            nib_cnt = 0;
            qclk_d  = 1'b0;
        end else begin
            if (esp_qclk && !qclk_d) begin
                if (esp_frame) begin
                    if (nib_cnt != 0) report_error("frame inside a word");
                    nib_cnt = 0;
                    frames_seen++;
                end else if (nib_cnt == 0) begin
                    report_error("word started without a frame");
                end
                rx_word = {rx_word[27:0], esp_qdata};
                nib_cnt++;
                if (nib_cnt == 8) begin
                    nib_cnt = 0;
                    check_word(rx_word);
                end
            end
            qclk_d = esp_qclk;
            if (overflow_led) overflow_seen = 1'b1;
            if ((frames_seen < activity_until) && !activity_led) begin
                report_error("activity_led low with words still queued");
            end
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        addr           <= 16'h0000;
        data           <= 8'h00;
        rw_n           <= 1'b1;
        m2sel_n        <= 1'b1;
        m2b0           <= 1'b0;
        sw_gs          <= 1'b0;
        data_in_strobe <= 1'b0;
        capture_enable <= 1'b0;
        capture_mode   <= 3'd0;
        rst_tb         <= 1'b0;
        cur_mode = MODE_ALL;
        void'($urandom(32'hef08));
        @(posedge a2bus_if);
        while (rst) @(posedge a2bus_if);
        @(negedge a2bus_if);
        check_idle("after reset");

        start_test();
        for (int m = 0; m < 8; m++) begin
            set_mode(1'b1, capture_mode_e'(m));
            for (int i = 0; i < 40; i++) begin
                drive_strobe(1'b1, 1'b0);
                idle(39);
            end
            drain();
        end
        end_test(1, "mode sweep");

        start_test();
        set_mode(1'b1, MODE_ALL);
        for (int i = 0; i < 20; i++) begin
            drive_strobe(i[0], i[0]);           // Enable low or slot not selected
            idle(3);
        end
        drain();
        if (rx_count != 0) report_error($sformatf("%0d words from gated strobes", rx_count));
        end_test(2, "gating");

        start_test();
        set_mode(1'b1, MODE_ALL);
        for (int i = 0; i < 3; i++) drive_strobe(1'b1, 1'b0);
        idle(1);
        @(negedge a2bus_if);
        while (!esp_frame) @(negedge a2bus_if);
        @(posedge a2bus_if);
        rst_tb <= 1'b1;
        repeat (4) @(posedge a2bus_if);
        rst_tb <= 1'b0;
        @(negedge a2bus_if);
        check_idle("during reset");
        if (activity_led || overflow_led || debug_status[1]) begin
            report_error("status outputs not cleared by reset");
        end
        exp_q.delete();
        for (int i = 0; i < 2; i++) drive_strobe(1'b1, 1'b0);
        drain();
        end_test(3, "link format");

        start_test();
        subseq_mode   = 1'b1;
        overflow_seen = 1'b0;
        set_mode(1'b1, MODE_ALL);
        for (int i = 0; i < 3 * DEPTH; i++) drive_strobe(1'b1, 1'b0);
        drain();
        subseq_mode = 1'b0;
        if (!overflow_seen) report_error("overflow_led never went high");
        if (rx_count < DEPTH + 1) report_error($sformatf("only %0d words in burst", rx_count));
        end_test(4, "burst overflow");

        start_test();
        set_mode(1'b1, MODE_ALL);
        for (int i = 0; i < 4; i++) drive_strobe(1'b1, 1'b0);
        activity_until = frames_seen + 4;       // Last frame empties the FIFO
        idle(1);
        while (frames_seen < activity_until) @(negedge a2bus_if);
        activity_until = 0;
        drain();
        for (int i = 0; i < 8; i++) begin
            set_mode(1'($urandom), capture_mode_e'(3'($urandom)));
            @(negedge a2bus_if);
            if (debug_status[5:2] != {capture_enable, capture_mode}) begin
                report_error($sformatf("debug_status %02h with enable %b mode %0d",
                                       debug_status, capture_enable, capture_mode));
            end
        end
        end_test(5, "status");

        $display("Summary: %0d tests, %0d words checked, %0d errors",
                 tests, words_checked, errors);
        verdict_done = 1'b1;
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge a2bus_if);
        $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG);
        verdict_done = 1'b1;
        $display("STATUS: FAIL");
        $finish;
    end

    // Run stopped early by the simulator, e.g. on an assertion
    final begin
        if (!verdict_done) begin
            $display("STATUS: FAIL");
        end
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+design
design/a2cap_pkg.sv
design/bus_cycle_if.sv
design/capture_push_if.sv
design/capture_filter.sv
design/nibble_stream_fifo.sv
design/a2bus_stream.sv
testbench/tb_clock_gen.sv
testbench/a2bus_stream_assert.sv
testbench/a2bus_stream_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the capture testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module a2bus_stream_tb \
    -Mdir obj_dir -o a2bus_stream_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/a2bus_stream_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0
